// ==== src/conv_defs.svh ====
// conv1 layer dimensions
// image, kernel, datapath widths and channel count for the first
// convolution layer of the digit classifier

`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// input image, one 8-bit pixel per clock in raster order
`define CONV_IMG_W 28
`define CONV_IMG_H 28

// square kernel side
`define CONV_K 5

`define CONV_PIX_W 8   // pixel and weight width
`define CONV_ACC_W 21  // exact for 25 products of 8x8 bits
`define CONV_OUT_W 12  // wrapped output width

// sum is scaled down by this many bits before the bias
`define CONV_SHIFT 8

`define CONV_CH 3

`endif

// ==== src/conv_pkg.sv ====
// conv1 layer types
// pixel, weight, window, kernel, accumulator and output types shared
// by the window buffer, the MACs and the bias stages

`default_nettype none

package conv_pkg;

    `include "conv_defs.svh"

    typedef logic [`CONV_PIX_W-1:0] pixel_t;          // unsigned grayscale
    typedef logic signed [`CONV_PIX_W-1:0] weight_t;  // weight or bias

    // index = row * K + column
    // row 0 is the oldest line, column 0 the oldest pixel
    typedef pixel_t [`CONV_K*`CONV_K-1:0] window_t;
    typedef weight_t [`CONV_K*`CONV_K-1:0] kernel_t;

    typedef logic signed [`CONV_ACC_W-1:0] acc_t;
    typedef logic signed [`CONV_OUT_W-1:0] conv_t;

endpackage

`default_nettype wire

// ==== src/conv_window_buffer.sv ====
// conv window buffer
// four line delays and a 5x5 shift-register window over the raster
// pixel stream; win_valid marks each complete window position

`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_window_buffer
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  pixel_t  data_in,
    output window_t window,
    output logic    win_valid
);

    localparam int COL_W = $clog2(`CONV_IMG_W);
    localparam int ROW_W = $clog2(`CONV_IMG_H);
    localparam int LINES = `CONV_K - 1;

    logic [COL_W-1:0] col_cnt;  // raster position of data_in
    logic [ROW_W-1:0] row_cnt;
    logic [COL_W-1:0] col_q;    // column of pix_q, line memory pointer
    logic             pos_ok;   // pix_q closes a full window

    pixel_t pix_q;
    pixel_t line_mem [LINES][`CONV_IMG_W];
    pixel_t tap [LINES];        // tap[k] is k+1 lines above pix_q

    // raster tracking, frame alignment comes from reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            col_q     <= '0;
            pos_ok    <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            col_q     <= col_cnt;
            pos_ok    <= (row_cnt >= ROW_W'(LINES)) && (col_cnt >= COL_W'(LINES));
            win_valid <= pos_ok;
            if (col_cnt == COL_W'(`CONV_IMG_W - 1)) begin
                col_cnt <= '0;
                if (row_cnt == ROW_W'(`CONV_IMG_H - 1)) begin
                    row_cnt <= '0;  // next frame follows directly
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // same column of the previous lines, read before this cycle's write
    always_comb begin
        for (int k = 0; k < LINES; k++) begin
            tap[k] = line_mem[k][col_q];
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= data_in;

        // cascade: each line memory feeds the one above it
        line_mem[0][col_q] <= pix_q;
        for (int k = 1; k < LINES; k++) begin
            line_mem[k][col_q] <= tap[k-1];
        end

        // shift the window left by one column
        for (int r = 0; r < `CONV_K; r++) begin
            for (int c = 0; c < `CONV_K - 1; c++) begin
                window[r*`CONV_K + c] <= window[r*`CONV_K + c + 1];
            end
        end

        // new right column, oldest line on top
        for (int r = 0; r < LINES; r++) begin
            window[r*`CONV_K + LINES] <= tap[LINES-1-r];
        end
        window[LINES*`CONV_K + LINES] <= pix_q;  // newest pixel, bottom right
    end

endmodule

`default_nettype wire

// ==== src/conv_mac.sv ====
// conv MAC
// 25-term multiply-accumulate of one window against one channel's
// kernel, exact in acc_t and registered with its strobe

`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_mac
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  window_t window,
    input  kernel_t kernel,
    input  logic    win_valid,
    output acc_t    sum,
    output logic    sum_valid
);

    acc_t sum_next;

    // pixels zero-extended, weights sign-extended; no overflow at 21 bits
    always_comb begin
        sum_next = '0;
        for (int i = 0; i < `CONV_K*`CONV_K; i++) begin
            sum_next = sum_next + acc_t'(window[i]) * acc_t'(signed'(kernel[i]));
        end
    end

    // sum register runs every cycle
    always_ff @(posedge clk) begin
        sum <= sum_next;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= win_valid;
        end
    end

endmodule

`default_nettype wire

// ==== src/conv_bias_out.sv ====
// conv bias and output stage
// floor-shifts the MAC sum, adds the sign-extended bias and registers
// the wrapped 12-bit result with its strobe

`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_bias_out
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  acc_t    sum,
    input  logic    sum_valid,
    input  weight_t bias,
    output conv_t   conv_out,
    output logic    out_valid
);

    acc_t  sum_scaled;
    conv_t result;

    assign sum_scaled = sum >>> `CONV_SHIFT;                  // rounds toward -inf
    assign result     = conv_t'(sum_scaled) + conv_t'(bias);  // wraps at 12 bits

    always_ff @(posedge clk) begin
        conv_out <= result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid;
        end
    end

endmodule

`default_nettype wire

// ==== src/conv1_layer.sv ====
// conv1 layer top
// one shared window buffer feeding three channel MACs and three
// bias/output stages; outputs appear three cycles after the last pixel

`timescale 1ns/1ps
`default_nettype none

module conv1_layer
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  pixel_t  data_in,
    input  kernel_t weight_1,
    input  kernel_t weight_2,
    input  kernel_t weight_3,
    input  weight_t bias_1,
    input  weight_t bias_2,
    input  weight_t bias_3,
    output conv_t   conv_out_1,
    output conv_t   conv_out_2,
    output conv_t   conv_out_3,
    output logic    valid_out
);

    window_t window;
    logic    win_valid;
    acc_t    sum_1, sum_2, sum_3;
    logic    sum_valid_1, sum_valid_2, sum_valid_3;

    conv_window_buffer u_window_buffer (
        .clk(clk), .rst_n(rst_n), .data_in(data_in),
        .window(window), .win_valid(win_valid)
    );

    conv_mac u_mac_1 (
        .clk(clk), .rst_n(rst_n), .window(window), .kernel(weight_1),
        .win_valid(win_valid), .sum(sum_1), .sum_valid(sum_valid_1)
    );
    conv_mac u_mac_2 (
        .clk(clk), .rst_n(rst_n), .window(window), .kernel(weight_2),
        .win_valid(win_valid), .sum(sum_2), .sum_valid(sum_valid_2)
    );
    conv_mac u_mac_3 (
        .clk(clk), .rst_n(rst_n), .window(window), .kernel(weight_3),
        .win_valid(win_valid), .sum(sum_3), .sum_valid(sum_valid_3)
    );

    // channel timing is identical, channel 1 carries the strobe
    conv_bias_out u_bias_out_1 (
        .clk(clk), .rst_n(rst_n), .sum(sum_1), .sum_valid(sum_valid_1),
        .bias(bias_1), .conv_out(conv_out_1), .out_valid(valid_out)
    );
    conv_bias_out u_bias_out_2 (
        .clk(clk), .rst_n(rst_n), .sum(sum_2), .sum_valid(sum_valid_2),
        .bias(bias_2), .conv_out(conv_out_2), .out_valid()
    );
    conv_bias_out u_bias_out_3 (
        .clk(clk), .rst_n(rst_n), .sum(sum_3), .sum_valid(sum_valid_3),
        .bias(bias_3), .conv_out(conv_out_3), .out_valid()
    );

endmodule

`default_nettype wire

// ==== testbench/conv1_layer_assertions.sv ====
// conv1 layer output assertions
// bound to the top level; watches the output strobe and channel values

`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv1_layer_assertions
    import conv_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  valid_out,
    input conv_t conv_out_1,
    input conv_t conv_out_2,
    input conv_t conv_out_3
);

    localparam int BURST = `CONV_IMG_W - `CONV_K + 1;  // windows per output row

    int run_len;           // consecutive valid cycles before this edge
    int fail_reset = 0;
    int fail_unknown = 0;
    int fail_burst = 0;
    int fail_count;

    assign fail_count = fail_reset + fail_unknown + fail_burst;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_len <= 0;
        end else if (valid_out) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |=> !valid_out)
        else begin
            $error("valid_out high in the cycle after a reset cycle");
            fail_reset++;
        end

    known_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> !$isunknown({conv_out_1, conv_out_2, conv_out_3}))
        else begin
            $error("unknown conv output while valid_out is high");
            fail_unknown++;
        end

    burst_length: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> run_len < BURST)
        else begin
            $error("valid_out burst longer than one output row");
            fail_burst++;
        end

endmodule

`default_nettype wire

// ==== testbench/conv1_layer_checker.sv ====
// conv1 layer checker
// stores each frame's pixels, models every window result in raster
// order and compares it with the DUT outputs, including pulse timing

`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv1_layer_checker
    import conv_pkg::*;
#(
    parameter int NUM_FRAMES = 1
) (
    input  logic    clk,
    input  logic    rst_n,
    input  pixel_t  data_in,
    input  kernel_t weight_1,
    input  kernel_t weight_2,
    input  kernel_t weight_3,
    input  weight_t bias_1,
    input  weight_t bias_2,
    input  weight_t bias_3,
    input  conv_t   conv_out_1,
    input  conv_t   conv_out_2,
    input  conv_t   conv_out_3,
    input  logic    valid_out,
    input  logic    exp_const,  // frame uses the table values
    input  conv_t   exp_1,
    input  conv_t   exp_2,
    input  conv_t   exp_3,
    output int      frames_done,
    output int      err_count,
    output int      check_count
);

    localparam int W = `CONV_IMG_W;
    localparam int K = `CONV_K;
    localparam int PIXELS = `CONV_IMG_W * `CONV_IMG_H;
    localparam int OUTS = (`CONV_IMG_W - K + 1) * (`CONV_IMG_H - K + 1);
    localparam int LATENCY = 4;  // pixel edge to the edge that sees valid_out

    pixel_t frame_px [PIXELS];
    int     due_q [$];           // cycle each output is expected
    int     pos_q [$];           // raster index of the window's last pixel
    conv_t  exp_q1 [$];
    conv_t  exp_q2 [$];
    conv_t  exp_q3 [$];
    int     cyc = 0;
    int     pix_idx = 0;
    int     frame_in = 0;
    int     resolved = 0;
    int     frames_q = 0;
    int     err_q = 0;
    int     check_q = 0;

    assign frames_done = frames_q;
    assign err_count   = err_q;
    assign check_count = check_q;

    // floor shift of the exact sum, then bias, wrapped to the output width
    function automatic conv_t model_out(input kernel_t w, input weight_t b, input int pos);
        int acc;
        int top;
        acc = 0;
        top = pos - (K - 1) * W - (K - 1);  // oldest pixel of the window
        for (int kr = 0; kr < K; kr++) begin
            for (int kc = 0; kc < K; kc++) begin
                acc += int'(frame_px[top + kr*W + kc]) * int'($signed(w[kr*K + kc]));
            end
        end
        return conv_t'((acc >>> `CONV_SHIFT) + int'(b));
    endfunction

    task automatic check_value(input int ch, input int pos, input conv_t got, input conv_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: channel %0d window row %0d col %0d got %0d expected %0d",
                     $time, ch, pos / W - (K - 1), pos % W - (K - 1), got, exp);
            err_q++;
        end
    endtask

    task automatic retire();
        void'(due_q.pop_front());
        void'(pos_q.pop_front());
        void'(exp_q1.pop_front());
        void'(exp_q2.pop_front());
        void'(exp_q3.pop_front());
        resolved++;
        if (resolved == OUTS) begin
            frames_q++;
            resolved = 0;
        end
    endtask

    always @(posedge clk) begin
        int r;
        int c;
        // outputs registered by the previous edge
        if (valid_out) begin
            if (due_q.size() == 0 || due_q[0] != cyc) begin
                $display("unexpected valid_out pulse at %0t with no window due", $time);
                err_q++;
            end else begin
                check_value(1, pos_q[0], conv_out_1, exp_q1[0]);
                check_value(2, pos_q[0], conv_out_2, exp_q2[0]);
                check_value(3, pos_q[0], conv_out_3, exp_q3[0]);
                check_q++;
                retire();
            end
        end else if (due_q.size() != 0 && due_q[0] == cyc) begin
            $display("missing valid_out at %0t for window ending at pixel %0d",
                     $time, pos_q[0]);
            err_q++;
            retire();
        end

        // pixel taken by the DUT on this edge
        if (rst_n) begin
            if (frame_in < NUM_FRAMES) begin
                frame_px[pix_idx] = data_in;
                r = pix_idx / W;
                c = pix_idx % W;
                if (r >= K - 1 && c >= K - 1) begin
                    due_q.push_back(cyc + LATENCY);
                    pos_q.push_back(pix_idx);
                    exp_q1.push_back(exp_const ? exp_1 : model_out(weight_1, bias_1, pix_idx));
                    exp_q2.push_back(exp_const ? exp_2 : model_out(weight_2, bias_2, pix_idx));
                    exp_q3.push_back(exp_const ? exp_3 : model_out(weight_3, bias_3, pix_idx));
                end
            end
            pix_idx++;
            if (pix_idx == PIXELS) begin  // frames run back to back
                pix_idx = 0;
                frame_in++;
            end
        end
        cyc++;
    end

endmodule

`default_nettype wire

// ==== testbench/conv1_layer_tb.sv ====
// conv1 layer testbench
// drives back-to-back frames from a stimulus table and reports per test

`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv1_layer_tb
    import conv_pkg::*;
();

    localparam int NUM_TESTS = 6;
    localparam int PIXELS = `CONV_IMG_W * `CONV_IMG_H;
    localparam int FRAME_TIMEOUT = 3 * PIXELS;
    localparam int FLUSH_CYCLES = 64;

    typedef struct packed {
        bit pix_rand;
        int pix_val;
        bit w_rand;
        int w1, w2, w3;
        int b1, b2, b3;
        bit use_model;
        int e1, e2, e3;
    } row_t;

    logic    clk = 1'b0;
    logic    rst_n;
    pixel_t  data_in;
    kernel_t weight_1, weight_2, weight_3;
    weight_t bias_1, bias_2, bias_3;
    conv_t   conv_out_1, conv_out_2, conv_out_3;
    logic    valid_out;
    logic    exp_const;
    conv_t   exp_1, exp_2, exp_3;
    int      frames_done, err_count, check_count;

    row_t        tests [NUM_TESTS];
    string       test_name [NUM_TESTS];
    logic [31:0] lfsr_q;

    always #2 clk = ~clk;

    conv1_layer conv1_layer_inst (.*);

    conv1_layer_checker #(.NUM_FRAMES(NUM_TESTS)) u_checker (.*);

    bind conv1_layer conv1_layer_assertions u_assertions (
        .clk(clk), .rst_n(rst_n), .valid_out(valid_out),
        .conv_out_1(conv_out_1), .conv_out_2(conv_out_2), .conv_out_3(conv_out_3)
    );

    task automatic load_table();
        // pix_rand pix w_rand  w1 w2 w3  b1 b2 b3  model  e1 e2 e3
        tests[0] = '{1'b0, 10, 1'b0, 4, 2, 1, 5, 0, -2, 1'b0, 8, 1, -2};
        tests[1] = '{1'b0, 255, 1'b0, -128, -1, 127, -1, 3, 0, 1'b0, 907, -22, -934};
        tests[2] = '{1'b0, 200, 1'b0, -3, 2, -7, -128, -50, 127, 1'b0, -187, -11, -10};
        tests[3] = '{1'b1, 0, 1'b1, 0, 0, 0, 17, -90, 64, 1'b1, 0, 0, 0};
        tests[4] = '{1'b1, 0, 1'b1, 0, 0, 0, -5, 33, -128, 1'b1, 0, 0, 0};
        tests[5] = '{1'b0, 100, 1'b0, 2, -2, 0, 1, 1, 1, 1'b0, 20, -19, 1};
        test_name = '{"const_pos", "neg_weights", "neg_bias",
                      "random_a", "random_b", "const_after_random"};
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic apply_params(input int t);
        for (int k = 0; k < `CONV_K * `CONV_K; k++) begin
            weight_1[k] = tests[t].w_rand ? weight_t'(take_bits(8)) : weight_t'(tests[t].w1);
            weight_2[k] = tests[t].w_rand ? weight_t'(take_bits(8)) : weight_t'(tests[t].w2);
            weight_3[k] = tests[t].w_rand ? weight_t'(take_bits(8)) : weight_t'(tests[t].w3);
        end
        bias_1    = weight_t'(tests[t].b1);
        bias_2    = weight_t'(tests[t].b2);
        bias_3    = weight_t'(tests[t].b3);
        exp_const = !tests[t].use_model;
        exp_1     = conv_t'(tests[t].e1);
        exp_2     = conv_t'(tests[t].e2);
        exp_3     = conv_t'(tests[t].e3);
    endtask

    // weights change a few pixels into the next frame, after the last
    // windows of the previous one have left the pipeline
    task automatic drive_frames();
        for (int f = 0; f < NUM_TESTS; f++) begin
            for (int i = 0; i < PIXELS; i++) begin
                if (f > 0 && i == 4) begin
                    apply_params(f);
                end
                data_in = tests[f].pix_rand ? pixel_t'(take_bits(8))
                                            : pixel_t'(tests[f].pix_val);
                @(negedge clk);
            end
        end
        repeat (FLUSH_CYCLES) begin
            data_in = '0;
            @(negedge clk);
        end
    endtask

    task automatic wait_frame(input int t, output bit ok);
        int n;
        n = 0;
        while (frames_done <= t && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = (frames_done > t);
    endtask

    initial begin
        bit ok;
        bit timed_out;
        int errs_before;
        int asserts;
        timed_out   = 1'b0;
        errs_before = 0;
        load_table();
        lfsr_q  = 32'h37b544f2;
        rst_n   = 1'b0;
        data_in = '0;
        apply_params(0);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        fork
            drive_frames();
        join_none
        for (int t = 0; t < NUM_TESTS; t++) begin
            wait_frame(t, ok);
            if (!ok) begin
                $display("timeout: test %s did not produce all its outputs", test_name[t]);
                timed_out = 1'b1;
                break;
            end
            $display("test %0d %-20s %s (%0d errors)", t, test_name[t],
                     (err_count == errs_before) ? "ok" : "mismatch", err_count - errs_before);
            errs_before = err_count;
        end
        asserts = conv1_layer_inst.u_assertions.fail_count;
        $display("tests %0d, outputs checked %0d, errors %0d, assertion failures %0d",
                 NUM_TESTS, check_count, err_count, asserts);
        if (!timed_out && err_count == 0 && asserts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/conv_pkg.sv
src/conv_window_buffer.sv
src/conv_mac.sv
src/conv_bias_out.sv
src/conv1_layer.sv
testbench/conv1_layer_assertions.sv
testbench/conv1_layer_checker.sv
testbench/conv1_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the conv1 layer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module conv1_layer_tb -f tb.f \
    --Mdir obj_dir -o conv1_layer_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/conv1_layer_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
echo "pass message not found"
exit 1
